//--- files.f
rtl/gw_tag_pkg.sv
rtl/gw_tag_lines_if.sv
rtl/gw_tag_boot_rom.sv
rtl/gw_tag_trace_replay.sv
rtl/gw_tag_master.sv
rtl/gw_tag_client.sv
rtl/gw_gateway_config.sv
verification/tb_gw_gateway_config.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the gateway configuration testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_gw_gateway_config \
  -f files.f

# The simulation exits non-zero on failure, so the log decides the result
./obj_dir/Vtb_gw_gateway_config > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with errors" sim.log; then
  echo "Simulation FAILED"
  exit 1
elif ! grep -q "Finished with no errors" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi

echo "Simulation PASSED"

//--- verification/tb_gw_gateway_config.sv
`timescale 1ns/1ns
`default_nettype none

module tb_gw_gateway_config;

  localparam int PROG_LEN = 11;
  // Boot program runs about 130 cycles, plus reset and tail, with ample margin
  localparam int TIMEOUT_CYCLES = 400;
  localparam logic [7:0] RESET_VALS [4] = '{8'h11, 8'h22, 8'h33, 8'h44};

  typedef struct packed {
    logic       is_send;
    logic [1:0] mask;
    logic       dnr;
    logic [1:0] id;
    logic [3:0] len;
    logic [7:0] payload;
  } prog_entry_t;

  logic       clk_i;
  logic       rst_n_i;
  logic       tag_en_o;
  logic       tag_data_o;
  logic       init_done_o;
  logic [7:0] cfg0_o;
  logic [7:0] cfg1_o;
  logic [7:0] cfg2_o;
  logic [7:0] cfg3_o;

  logic        rst_d = 1'b0;
  int          cycle_cnt = 0;
  prog_entry_t prog [PROG_LEN];
  logic [7:0]  exp_cfg [4];
  int          ext_expect_q [$];
  logic        rx_bits [$];

  gw_gateway_config UUT (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .tag_en_o    (tag_en_o),
    .tag_data_o  (tag_data_o),
    .init_done_o (init_done_o),
    .cfg0_o      (cfg0_o),
    .cfg1_o      (cfg1_o),
    .cfg2_o      (cfg2_o),
    .cfg3_o      (cfg3_o)
  );

  //////////////////////////////////////////////////
  // Failure reporting

  task automatic stop_failing();
    $display("Finished with errors");
    $fatal(1, "simulation stopped");
  endtask

  task automatic value_error(input string msg);
    $display("ERR at %0t: %s", $time, msg);
    stop_failing();
  endtask

  //////////////////////////////////////////////////
  // Program table and expected settings

  task automatic load_program();
    prog[0] = '{1'b1, 2'b11, 1'b0, 2'd0, 4'd0, 8'h00};
    prog[1] = '{1'b1, 2'b11, 1'b0, 2'd1, 4'd0, 8'h00};
    prog[2] = '{1'b1, 2'b11, 1'b0, 2'd2, 4'd0, 8'h00};
    prog[3] = '{1'b1, 2'b11, 1'b0, 2'd3, 4'd0, 8'h00};
    prog[4] = '{1'b1, 2'b11, 1'b1, 2'd0, 4'd8, 8'hA5};
    prog[5] = '{1'b1, 2'b01, 1'b1, 2'd1, 4'd4, 8'h09};
    // Wait entry, six idle cycles
    prog[6] = '{1'b0, 2'b00, 1'b0, 2'd0, 4'd0, 8'd6};
    prog[7] = '{1'b1, 2'b10, 1'b1, 2'd2, 4'd8, 8'h5A};
    prog[8] = '{1'b1, 2'b11, 1'b1, 2'd3, 4'd8, 8'hC3};
    prog[9] = '{1'b1, 2'b01, 1'b0, 2'd3, 4'd0, 8'h00};
    prog[10] = '{1'b1, 2'b01, 1'b1, 2'd3, 4'd3, 8'h06};
  endtask

  function automatic logic [7:0] model_setting(input int client);
    logic [7:0] val;
    int         i;
    int         b;
    val = RESET_VALS[client];
    for (i = 0; i < PROG_LEN; i++)
    begin
      if (prog[i].is_send && prog[i].mask[0] && int'(prog[i].id) == client)
      begin
        if (!prog[i].dnr)
          val = RESET_VALS[client];
        else
          for (b = 0; b < 8; b++)
            if (b < int'(prog[i].len))
              val[b] = prog[i].payload[b];
      end
    end
    return val;
  endfunction

  task automatic build_model();
    int i;
    for (i = 0; i < 4; i++)
      exp_cfg[i] = model_setting(i);
    for (i = 0; i < PROG_LEN; i++)
      if (prog[i].is_send && prog[i].mask[1])
        ext_expect_q.push_back(i);
  endtask

  //////////////////////////////////////////////////
  // External packet decoder

  task automatic check_ext_packet();
    prog_entry_t want;
    logic        dnr;
    logic [1:0]  id;
    logic [3:0]  len;
    logic [7:0]  payload;
    int          n;
    int          i;
    assert (ext_expect_q.size() != 0)
      else value_error("packet on tag pins beyond the expected master 1 entries");
    want = prog[ext_expect_q.pop_front()];
    n = rx_bits.size();
    assert (n >= 8 && rx_bits[0] == 1'b1)
      else value_error($sformatf("malformed packet of %0d bits on tag pins", n));
    dnr = rx_bits[1];
    id  = {rx_bits[3], rx_bits[2]};
    len = {rx_bits[7], rx_bits[6], rx_bits[5], rx_bits[4]};
    assert (len <= 4'd8 && n == 8 + int'(len))
      else value_error($sformatf("packet length %0d with %0d bits on tag pins", len, n));
    payload = '0;
    for (i = 0; i < int'(len); i++)
      payload[i] = rx_bits[8 + i];
    assert (dnr == want.dnr && id == want.id && len == want.len && payload == want.payload)
      else value_error($sformatf("tag pins sent dnr %0b id %0d len %0d payload %h, %s",
                                 dnr, id, len, payload,
                                 $sformatf("want %0b %0d %0d %h", want.dnr, want.id,
                                           want.len, want.payload)));
  endtask

  always @(negedge clk_i)
  begin
    if (tag_en_o)
    begin
      rx_bits.push_back(tag_data_o);
    end
    else if (rx_bits.size() != 0)
    begin
      check_ext_packet();
      rx_bits.delete();
    end
  end

  //////////////////////////////////////////////////
  // Assertions

  always @(posedge clk_i)
    rst_d <= rst_n_i;

  a_reset_state: assert property (@(posedge clk_i)
    (!rst_n_i || !rst_d) |-> (!tag_en_o && !tag_data_o && !init_done_o &&
      cfg0_o == RESET_VALS[0] && cfg1_o == RESET_VALS[1] &&
      cfg2_o == RESET_VALS[2] && cfg3_o == RESET_VALS[3]))
    else value_error("outputs not at their reset values around reset");

  a_no_ext_after_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    init_done_o |-> !tag_en_o)
    else value_error("tag pins active after init_done_o");

  a_cfg2_untouched: assert property (@(posedge clk_i)
    cfg2_o == RESET_VALS[2])
    else value_error($sformatf("cfg2_o is %h, master 1 write leaked in", cfg2_o));

  a_final_cfg: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(init_done_o) |-> (cfg0_o == exp_cfg[0] && cfg1_o == exp_cfg[1] &&
      cfg2_o == exp_cfg[2] && cfg3_o == exp_cfg[3]))
    else value_error($sformatf("settings at init_done_o %h %h %h %h, want %h %h %h %h",
                               cfg0_o, cfg1_o, cfg2_o, cfg3_o,
                               exp_cfg[0], exp_cfg[1], exp_cfg[2], exp_cfg[3]));

  a_done_holds: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    init_done_o |=> init_done_o)
    else value_error("init_done_o dropped");

  //////////////////////////////////////////////////
  // Clock, reset, timeout

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: init_done_o did not rise within %0d cycles", TIMEOUT_CYCLES);
      stop_failing();
    end
  end

  initial
  begin
    rst_n_i = 1'b1;
    load_program();
    build_model();
    // Falling edge so the asynchronous reset fires
    #1;
    rst_n_i = 1'b0;
    repeat (8) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    wait (init_done_o);
    repeat (20) @(posedge clk_i);
    @(negedge clk_i);
    if (init_done_o && ext_expect_q.size() == 0 && cfg0_o == exp_cfg[0] &&
        cfg1_o == exp_cfg[1] && cfg2_o == exp_cfg[2] && cfg3_o == exp_cfg[3])
    begin
      $display("Finished with no errors");
      $finish;
    end
    else
    begin
      value_error($sformatf("final state done %0b, %0d packets missing, cfg %h %h %h %h",
                            init_done_o, ext_expect_q.size(),
                            cfg0_o, cfg1_o, cfg2_o, cfg3_o));
    end
  end

endmodule

`default_nettype wire

//--- rtl/gw_gateway_config.sv
`timescale 1ns/1ns
`default_nettype none

module gw_gateway_config (
  input  wire                      clk_i,
  input  wire                      rst_n_i,
  output logic                     tag_en_o,
  output logic                     tag_data_o,
  output logic                     init_done_o,
  output gw_tag_pkg::tag_payload_t cfg0_o,
  output gw_tag_pkg::tag_payload_t cfg1_o,
  output gw_tag_pkg::tag_payload_t cfg2_o,
  output gw_tag_pkg::tag_payload_t cfg3_o
);

  //////////////////////////////////////////////////
  // Trace ROM and replay

  gw_tag_pkg::rom_addr_t    rom_addr;
  gw_tag_pkg::rom_word_t    rom_data;
  logic                     trace_valid;
  gw_tag_pkg::tag_masters_t trace_en_r;
  logic                     trace_data;
  logic                     trace_done;

  gw_tag_boot_rom u_rom (
    .addr_i (rom_addr),
    .data_o (rom_data)
  );

  gw_tag_trace_replay u_replay (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .rom_addr_o (rom_addr),
    .rom_data_i (rom_data),
    .valid_o    (trace_valid),
    .en_r_o     (trace_en_r),
    .tag_data_o (trace_data),
    .done_o     (trace_done)
  );

  // Master 1 goes off chip
  assign tag_en_o   = trace_valid & trace_en_r[1];
  assign tag_data_o = trace_data;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      init_done_o <= 1'b0;
    end
    else
    begin
      init_done_o <= trace_done;
    end
  end

  //////////////////////////////////////////////////
  // On-board master and clients

  logic                     master_data;
  gw_tag_pkg::tag_payload_t cfg [gw_tag_pkg::TAG_NUM_CLIENTS];

  gw_tag_lines_if tag_lines ();

  // Master 0 only sees its own packets
  assign master_data = trace_valid & trace_en_r[0] & trace_data;

  gw_tag_master u_master (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .data_i    (master_data),
    .tag_lines (tag_lines)
  );

  for (genvar i = 0; i < gw_tag_pkg::TAG_NUM_CLIENTS; i++)
  begin : g_client
    gw_tag_client #(
      .CLIENT_ID (i)
    ) u_client (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .tag_lines (tag_lines),
      .cfg_o     (cfg[i])
    );
  end

  assign cfg0_o = cfg[0];
  assign cfg1_o = cfg[1];
  assign cfg2_o = cfg[2];
  assign cfg3_o = cfg[3];

endmodule

`default_nettype wire

//--- rtl/gw_tag_client.sv
`timescale 1ns/1ns
`default_nettype none

module gw_tag_client #(
  parameter int unsigned CLIENT_ID = 0
) (
  input wire                       clk_i,
  input wire                       rst_n_i,
  gw_tag_lines_if.client           tag_lines,
  output gw_tag_pkg::tag_payload_t cfg_o
);

  localparam gw_tag_pkg::tag_payload_t RESET_VAL =
    gw_tag_pkg::CLIENT_RESET_VALUES[CLIENT_ID];

  gw_tag_pkg::tag_payload_t cfg_q;
  gw_tag_pkg::tag_payload_t write_mask;
  logic                     strobe;

  assign strobe = tag_lines.client_v[CLIENT_ID];

  // Low len bits set, len of 8 covers the whole byte
  assign write_mask = ~({gw_tag_pkg::TAG_MAX_PAYLOAD{1'b1}} << tag_lines.len);

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      cfg_q <= RESET_VAL;
    end
    else if (strobe)
    begin
      if (!tag_lines.data_not_reset)
      begin
        cfg_q <= RESET_VAL;
      end
      else
      begin
        cfg_q <= (cfg_q & ~write_mask) | (tag_lines.payload & write_mask);
      end
    end
  end

  assign cfg_o = cfg_q;

  a_len_in_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    strobe |-> (tag_lines.len <= gw_tag_pkg::TAG_LEN_W'(gw_tag_pkg::TAG_MAX_PAYLOAD)))
    else $error("client %0d: strobe with len above max payload", CLIENT_ID);

endmodule

`default_nettype wire

//--- rtl/gw_tag_master.sv
`timescale 1ns/1ns
`default_nettype none

module gw_tag_master (
  input wire             clk_i,
  input wire             rst_n_i,
  input wire             data_i,
  gw_tag_lines_if.master tag_lines
);

  localparam int NC = gw_tag_pkg::TAG_NUM_CLIENTS;

  // Seven header bits follow the start bit
  localparam gw_tag_pkg::tag_len_t HDR_LAST =
    gw_tag_pkg::tag_len_t'(gw_tag_pkg::TAG_PKT_HDR_BITS - 2);

  typedef enum logic [1:0] {
    M_IDLE,
    M_HDR,
    M_PAYLOAD
  } master_state_e;

  master_state_e               state_q;
  gw_tag_pkg::tag_len_t        cnt_q;
  logic [NC-1:0]               client_v_q;
  logic                        dnr_q;
  gw_tag_pkg::tag_client_id_t  id_q;
  gw_tag_pkg::tag_len_t        len_q;
  gw_tag_pkg::tag_payload_t    payload_q;

  gw_tag_pkg::tag_len_t        len_next;
  logic [NC-1:0]               id_onehot;

  // Length as it stands once the last header bit is in
  assign len_next  = {data_i, len_q[2:0]};
  assign id_onehot = {{(NC-1){1'b0}}, 1'b1} << id_q;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q    <= M_IDLE;
      cnt_q      <= '0;
      client_v_q <= '0;
    end
    else
    begin
      client_v_q <= '0;
      case (state_q)
        M_IDLE:
        begin
          cnt_q <= '0;
          if (data_i)
          begin
            state_q <= M_HDR;
          end
        end
        M_HDR:
        begin
          cnt_q <= cnt_q + 4'd1;
          if (cnt_q == HDR_LAST)
          begin
            cnt_q <= '0;
            if (len_next == '0)
            begin
              client_v_q <= id_onehot;
              state_q    <= M_IDLE;
            end
            else
            begin
              state_q <= M_PAYLOAD;
            end
          end
        end
        M_PAYLOAD:
        begin
          cnt_q <= cnt_q + 4'd1;
          if (cnt_q == len_q - 4'd1)
          begin
            client_v_q <= id_onehot;
            state_q    <= M_IDLE;
          end
        end
        default:
        begin
          state_q <= M_IDLE;
        end
      endcase
    end
  end

  // Header and payload capture
  always_ff @(posedge clk_i)
  begin
    case (state_q)
      M_IDLE:
      begin
        payload_q <= '0;
      end
      M_HDR:
      begin
        case (cnt_q)
          4'd0:    dnr_q    <= data_i;
          4'd1:    id_q[0]  <= data_i;
          4'd2:    id_q[1]  <= data_i;
          4'd3:    len_q[0] <= data_i;
          4'd4:    len_q[1] <= data_i;
          4'd5:    len_q[2] <= data_i;
          default: len_q[3] <= data_i;
        endcase
      end
      M_PAYLOAD:
      begin
        payload_q[cnt_q[2:0]] <= data_i;
      end
      default:
      begin
        payload_q <= payload_q;
      end
    endcase
  end

  assign tag_lines.client_v       = client_v_q;
  assign tag_lines.data_not_reset = dnr_q;
  assign tag_lines.len            = len_q;
  assign tag_lines.payload        = payload_q;

  a_strobe_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (|tag_lines.client_v) |=> (tag_lines.client_v == '0))
    else $error("master: client strobe held for more than one cycle");

endmodule

`default_nettype wire

//--- rtl/gw_tag_trace_replay.sv
`timescale 1ns/1ns
`default_nettype none

module gw_tag_trace_replay (
  input  wire                            clk_i,
  input  wire                            rst_n_i,
  output gw_tag_pkg::rom_addr_t          rom_addr_o,
  input  wire gw_tag_pkg::rom_word_t     rom_data_i,
  output logic                           valid_o,
  output gw_tag_pkg::tag_masters_t       en_r_o,
  output logic                           tag_data_o,
  output logic                           done_o
);

  localparam int PKT_W = gw_tag_pkg::TAG_PKT_MAX_BITS;

  gw_tag_pkg::replay_state_e   state_q;
  gw_tag_pkg::rom_addr_t       addr_q;
  gw_tag_pkg::tag_masters_t    mask_q;
  logic [PKT_W-1:0]            shift_q;
  gw_tag_pkg::tag_bit_cnt_t    bits_left_q;
  gw_tag_pkg::tag_payload_t    wait_q;

  gw_tag_pkg::trace_op_e       rom_op;
  gw_tag_pkg::tag_masters_t    rom_mask;
  logic                        rom_dnr;
  gw_tag_pkg::tag_client_id_t  rom_id;
  gw_tag_pkg::tag_len_t        rom_len;
  gw_tag_pkg::tag_payload_t    rom_payload;
  logic                        load_send;

  //////////////////////////////////////////////////
  // ROM word fields

  assign rom_op      = gw_tag_pkg::trace_op_e'(rom_data_i[gw_tag_pkg::ROM_OP_LSB +: 4]);
  assign rom_mask    = rom_data_i[gw_tag_pkg::ROM_MASK_LSB +: gw_tag_pkg::TAG_NUM_MASTERS];
  assign rom_dnr     = rom_data_i[gw_tag_pkg::ROM_DNR_BIT];
  assign rom_id      = rom_data_i[gw_tag_pkg::ROM_ID_LSB +: gw_tag_pkg::TAG_ID_W];
  assign rom_len     = rom_data_i[gw_tag_pkg::ROM_LEN_LSB +: gw_tag_pkg::TAG_LEN_W];
  assign rom_payload = rom_data_i[gw_tag_pkg::ROM_PAYLOAD_LSB +: gw_tag_pkg::TAG_MAX_PAYLOAD];

  assign load_send = (state_q == gw_tag_pkg::ST_FETCH) && (rom_op == gw_tag_pkg::OP_SEND);

  //////////////////////////////////////////////////
  // Sequencer

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q     <= gw_tag_pkg::ST_FETCH;
      addr_q      <= '0;
      bits_left_q <= '0;
      wait_q      <= '0;
    end
    else
    begin
      case (state_q)
        gw_tag_pkg::ST_FETCH:
        begin
          case (rom_op)
            gw_tag_pkg::OP_SEND:
            begin
              bits_left_q <= gw_tag_pkg::tag_bit_cnt_t'(gw_tag_pkg::TAG_PKT_HDR_BITS)
                             + {1'b0, rom_len};
              addr_q      <= addr_q + 5'd1;
              state_q     <= gw_tag_pkg::ST_SHIFT;
            end
            gw_tag_pkg::OP_WAIT:
            begin
              wait_q <= rom_payload;
              addr_q <= addr_q + 5'd1;
              // Zero-length wait goes straight to the next word
              if (rom_payload != '0)
              begin
                state_q <= gw_tag_pkg::ST_WAIT;
              end
            end
            default:
            begin
              state_q <= gw_tag_pkg::ST_DONE;
            end
          endcase
        end
        gw_tag_pkg::ST_SHIFT:
        begin
          bits_left_q <= bits_left_q - 5'd1;
          if (bits_left_q == 5'd1)
          begin
            state_q <= gw_tag_pkg::ST_FETCH;
          end
        end
        gw_tag_pkg::ST_WAIT:
        begin
          wait_q <= wait_q - 8'd1;
          if (wait_q == 8'd1)
          begin
            state_q <= gw_tag_pkg::ST_FETCH;
          end
        end
        default:
        begin
          state_q <= gw_tag_pkg::ST_DONE;
        end
      endcase
    end
  end

  // Packet image, start bit in the LSB
  always_ff @(posedge clk_i)
  begin
    if (load_send)
    begin
      shift_q <= {rom_payload, rom_len, rom_id, rom_dnr, 1'b1};
      mask_q  <= rom_mask;
    end
    else if (state_q == gw_tag_pkg::ST_SHIFT)
    begin
      shift_q <= {1'b0, shift_q[PKT_W-1:1]};
    end
  end

  assign rom_addr_o = addr_q;
  assign valid_o    = (state_q == gw_tag_pkg::ST_SHIFT);
  assign en_r_o     = mask_q;
  assign tag_data_o = valid_o & shift_q[0];
  assign done_o     = (state_q == gw_tag_pkg::ST_DONE);

  a_no_valid_when_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    done_o |=> (done_o && !valid_o))
    else $error("replay: valid_o high or done_o dropped after done");

  a_addr_frozen_when_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (state_q == gw_tag_pkg::ST_DONE) |=> $stable(rom_addr_o))
    else $error("replay: ROM address moved in ST_DONE");

endmodule

`default_nettype wire

//--- rtl/gw_tag_boot_rom.sv
`timescale 1ns/1ns
`default_nettype none

module gw_tag_boot_rom (
  input  wire gw_tag_pkg::rom_addr_t addr_i,
  output gw_tag_pkg::rom_word_t      data_o
);

  function automatic gw_tag_pkg::rom_word_t entry(
    input gw_tag_pkg::trace_op_e      op,
    input gw_tag_pkg::tag_masters_t   mask,
    input logic                       dnr,
    input gw_tag_pkg::tag_client_id_t id,
    input gw_tag_pkg::tag_len_t       len,
    input gw_tag_pkg::tag_payload_t   payload
  );
    return {op, mask, dnr, id, len, payload};
  endfunction

  //////////////////////////////////////////////////
  // Boot program
  // mask bit 0 is the on-board master, bit 1 the pins

  always_comb
  begin
    case (addr_i)
      // Reset every client
      5'd0:    data_o = entry(gw_tag_pkg::OP_SEND, 2'b11, 1'b0, 2'd0, 4'd0, 8'h00);
      5'd1:    data_o = entry(gw_tag_pkg::OP_SEND, 2'b11, 1'b0, 2'd1, 4'd0, 8'h00);
      5'd2:    data_o = entry(gw_tag_pkg::OP_SEND, 2'b11, 1'b0, 2'd2, 4'd0, 8'h00);
      5'd3:    data_o = entry(gw_tag_pkg::OP_SEND, 2'b11, 1'b0, 2'd3, 4'd0, 8'h00);
      // Full and partial writes
      5'd4:    data_o = entry(gw_tag_pkg::OP_SEND, 2'b11, 1'b1, 2'd0, 4'd8, 8'hA5);
      5'd5:    data_o = entry(gw_tag_pkg::OP_SEND, 2'b01, 1'b1, 2'd1, 4'd4, 8'h09);
      5'd6:    data_o = entry(gw_tag_pkg::OP_WAIT, 2'b00, 1'b0, 2'd0, 4'd0, 8'd6);
      5'd7:    data_o = entry(gw_tag_pkg::OP_SEND, 2'b10, 1'b1, 2'd2, 4'd8, 8'h5A);
      5'd8:    data_o = entry(gw_tag_pkg::OP_SEND, 2'b11, 1'b1, 2'd3, 4'd8, 8'hC3);
      // Client 3 reset, then 3 low bits
      5'd9:    data_o = entry(gw_tag_pkg::OP_SEND, 2'b01, 1'b0, 2'd3, 4'd0, 8'h00);
      5'd10:   data_o = entry(gw_tag_pkg::OP_SEND, 2'b01, 1'b1, 2'd3, 4'd3, 8'h06);
      5'd11:   data_o = entry(gw_tag_pkg::OP_DONE, 2'b00, 1'b0, 2'd0, 4'd0, 8'h00);
      default: data_o = entry(gw_tag_pkg::OP_DONE, 2'b00, 1'b0, 2'd0, 4'd0, 8'h00);
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/gw_tag_lines_if.sv
`timescale 1ns/1ns
`default_nettype none

interface gw_tag_lines_if;

  // One strobe bit per client
  logic [gw_tag_pkg::TAG_NUM_CLIENTS-1:0] client_v;
  logic                                   data_not_reset;
  gw_tag_pkg::tag_len_t                   len;
  gw_tag_pkg::tag_payload_t               payload;

  modport master (
    output client_v,
    output data_not_reset,
    output len,
    output payload
  );

  modport client (
    input client_v,
    input data_not_reset,
    input len,
    input payload
  );

endinterface

`default_nettype wire

//--- rtl/gw_tag_pkg.sv
`default_nettype none

package gw_tag_pkg;

  // Tag network geometry
  localparam int TAG_NUM_MASTERS  = 2;
  localparam int TAG_NUM_CLIENTS  = 4;
  localparam int TAG_MAX_PAYLOAD  = 8;
  localparam int TAG_ID_W         = 2;
  localparam int TAG_LEN_W        = 4;

  // Start, data_not_reset, id and len ahead of the payload
  localparam int TAG_PKT_HDR_BITS = 8;
  localparam int TAG_PKT_MAX_BITS = TAG_PKT_HDR_BITS + TAG_MAX_PAYLOAD;

  typedef logic [TAG_ID_W-1:0]        tag_client_id_t;
  typedef logic [TAG_LEN_W-1:0]       tag_len_t;
  typedef logic [TAG_MAX_PAYLOAD-1:0] tag_payload_t;
  typedef logic [TAG_NUM_MASTERS-1:0] tag_masters_t;
  typedef logic [4:0]                 tag_bit_cnt_t;

  // ROM word, opcode on top and payload at the bottom
  localparam int ROM_PAYLOAD_LSB  = 0;
  localparam int ROM_LEN_LSB      = ROM_PAYLOAD_LSB + TAG_MAX_PAYLOAD;
  localparam int ROM_ID_LSB       = ROM_LEN_LSB + TAG_LEN_W;
  localparam int ROM_DNR_BIT      = ROM_ID_LSB + TAG_ID_W;
  localparam int ROM_MASK_LSB     = ROM_DNR_BIT + 1;
  localparam int ROM_OP_LSB       = ROM_MASK_LSB + TAG_NUM_MASTERS;
  localparam int ROM_WORD_W       = ROM_OP_LSB + 4;

  typedef logic [4:0]            rom_addr_t;
  typedef logic [ROM_WORD_W-1:0] rom_word_t;

  typedef enum logic [3:0] {
    OP_SEND = 4'd1,
    OP_WAIT = 4'd2,
    OP_DONE = 4'd3
  } trace_op_e;

  typedef enum logic [1:0] {
    ST_FETCH,
    ST_SHIFT,
    ST_WAIT,
    ST_DONE
  } replay_state_e;

  // Settings restored by a reset packet, client 0 in the low byte
  localparam logic [TAG_NUM_CLIENTS-1:0][TAG_MAX_PAYLOAD-1:0] CLIENT_RESET_VALUES =
    {8'h44, 8'h33, 8'h22, 8'h11};

endpackage

`default_nettype wire
